/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_hist_builder
FILELIST  = hist_builder.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hist_bin_ram.sv */
`timescale 1ns/1ps
`include "hist_macros.svh"

module hist_bin_ram (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  inc_en,
    input  hist_pkg::hist_event_t inc_ev,
    input  logic                  clr_en,
    input  logic [`HIST_NB-1:0]   clr_addr,
    input  logic                  rd_en,
    input  logic [`HIST_NB-1:0]   rd_addr,
    input  logic                  rd_last,
    output logic                  ram_idle,
    output logic                  rd_valid,
    output logic                  rd_last_q,
    output hist_pkg::hist_bin_t   rd_bin
);

    logic [`HIST_PEAK_MAX-1:0] mem [`HIST_BIN_NUM];

    logic                      s1_v, s2_v;
    logic [`HIST_NB-1:0]       s1_addr, s2_addr;
    logic [`HIST_PEAK_MAX-1:0] s2_count;
    logic [`HIST_PEAK_MAX-1:0] cur, nxt;
    logic                      rd_go, clr_go;

    assign ram_idle = !s1_v && !s2_v;
    assign rd_go    = rd_en && ram_idle;
    assign clr_go   = clr_en && ram_idle;

    // take the count still waiting in stage 2 when it hits the same bin.
    assign cur = (s2_v && (s2_addr == s1_addr)) ? s2_count : mem[s1_addr];
    assign nxt = (&cur) ? cur : cur + 1'b1; // saturate.

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_v      <= 1'b0;
            s2_v      <= 1'b0;
            rd_valid  <= 1'b0;
            rd_last_q <= 1'b0;
        end else begin
            s1_v      <= inc_en;
            s2_v      <= s1_v;
            rd_valid  <= rd_go;
            rd_last_q <= rd_go && rd_last;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr  <= inc_ev.addr;
        s2_addr  <= s1_addr;
        s2_count <= nxt;
        if (rd_go) begin
            rd_bin.idx   <= rd_addr;
            rd_bin.count <= mem[rd_addr];
        end
        if (clr_go) mem[clr_addr] <= '0;
        else if (s2_v) mem[s2_addr] <= s2_count;
    end

endmodule

/* hist_builder.f */
+incdir+.
hist_pkg.sv
hist_seq_fsm.sv
hist_bin_ram.sv
hist_readout.sv
hist_builder.sv
tb_hist_builder.sv

/* hist_builder.sv */
`timescale 1ns/1ps
`include "hist_macros.svh"

module hist_builder (
    input  logic                clk,
    input  logic                res,
    input  logic                wr_en,
    input  logic [`HIST_NB-1:0] addr,
    output logic                busy,
    output logic                bin_valid,
    output logic                data_finish,
    output hist_pkg::hist_bin_t bin_out
);

    hist_pkg::hist_event_t ev;
    hist_pkg::hist_event_t inc_ev;
    hist_pkg::hist_bin_t   rd_bin;

    logic                inc_en, clr_en, rd_en, rd_last;
    logic [`HIST_NB-1:0] clr_addr, rd_addr;
    logic                ram_idle, rd_valid, rd_last_q;

    assign ev.addr = addr;

    hist_seq_fsm i_hist_seq_fsm (
        .clk      (clk),
        .res      (res),
        .wr_en    (wr_en),
        .ev       (ev),
        .ram_idle (ram_idle),
        .busy     (busy),
        .inc_en   (inc_en),
        .inc_ev   (inc_ev),
        .clr_en   (clr_en),
        .clr_addr (clr_addr),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_last  (rd_last)
    );

    hist_bin_ram i_hist_bin_ram (
        .clk       (clk),
        .res       (res),
        .inc_en    (inc_en),
        .inc_ev    (inc_ev),
        .clr_en    (clr_en),
        .clr_addr  (clr_addr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_last   (rd_last),
        .ram_idle  (ram_idle),
        .rd_valid  (rd_valid),
        .rd_last_q (rd_last_q),
        .rd_bin    (rd_bin)
    );

    hist_readout i_hist_readout (
        .clk         (clk),
        .res         (res),
        .rd_valid    (rd_valid),
        .rd_last_q   (rd_last_q),
        .rd_bin      (rd_bin),
        .bin_valid   (bin_valid),
        .data_finish (data_finish),
        .bin_out     (bin_out)
    );

endmodule

/* hist_macros.svh */
`ifndef HIST_MACROS_SVH
`define HIST_MACROS_SVH

// bin address width.
`define HIST_NB 4

// number of histogram bins.
`define HIST_BIN_NUM (1 << `HIST_NB)

// width of one bin count, counts saturate at all ones.
`define HIST_PEAK_MAX 8

// events that make up one pixel.
`define HIST_DATA_NUM 4

// pixels that make up one acquisition.
`define HIST_PIXEL_NUM 8

// acquisitions that complete one histogram.
`define HIST_ACQ_NUM 10

`endif

/* hist_pkg.sv */
`include "hist_macros.svh"

package hist_pkg;

    // sequencer states.
    typedef enum logic [2:0] {
        CLEAR_ALL   = 3'd0, // zero every bin.
        INPUT_COUNT = 3'd1, // accepting events within a pixel.
        PIXEL_COUNT = 3'd2, // last event closed a pixel.
        ACQ_COUNT   = 3'd3, // last event closed an acquisition.
        DRAIN       = 3'd4, // wait for the increment pipeline to empty.
        READOUT     = 3'd5  // stream every bin out.
    } hist_state_e;

    // one timing event.
    typedef struct packed {
        logic [`HIST_NB-1:0] addr; // time bin.
    } hist_event_t;

    // one output bin.
    typedef struct packed {
        logic [`HIST_NB-1:0]       idx;
        logic [`HIST_PEAK_MAX-1:0] count;
    } hist_bin_t;

endpackage

/* hist_readout.sv */
`timescale 1ns/1ps

module hist_readout (
    input  logic                clk,
    input  logic                res,
    input  logic                rd_valid,
    input  logic                rd_last_q,
    input  hist_pkg::hist_bin_t rd_bin,
    output logic                bin_valid,
    output logic                data_finish,
    output hist_pkg::hist_bin_t bin_out
);

    // strobes, cleared on reset.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bin_valid   <= 1'b0;
            data_finish <= 1'b0;
        end else begin
            bin_valid   <= rd_valid;
            data_finish <= rd_valid && rd_last_q; // marks the top bin.
        end
    end

    // bin payload holds its last value between streams.
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            bin_out <= rd_bin;
        end
    end

endmodule

/* hist_seq_fsm.sv */
`timescale 1ns/1ps
`include "hist_macros.svh"

module hist_seq_fsm (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  wr_en,
    input  hist_pkg::hist_event_t ev,
    input  logic                  ram_idle,
    output logic                  busy,
    output logic                  inc_en,
    output hist_pkg::hist_event_t inc_ev,
    output logic                  clr_en,
    output logic [`HIST_NB-1:0]   clr_addr,
    output logic                  rd_en,
    output logic [`HIST_NB-1:0]   rd_addr,
    output logic                  rd_last
);

    localparam int IN_W  = $clog2(`HIST_DATA_NUM);
    localparam int PIX_W = $clog2(`HIST_PIXEL_NUM);
    localparam int ACQ_W = $clog2(`HIST_ACQ_NUM);

    localparam logic [IN_W-1:0]  IN_MAX  = IN_W'(`HIST_DATA_NUM - 1);
    localparam logic [PIX_W-1:0] PIX_MAX = PIX_W'(`HIST_PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0] ACQ_MAX = ACQ_W'(`HIST_ACQ_NUM - 1);

    hist_pkg::hist_state_e state, next_state;

    logic [IN_W-1:0]     in_cnt;
    logic [PIX_W-1:0]    pix_cnt;
    logic [ACQ_W-1:0]    acq_cnt;
    logic [`HIST_NB-1:0] ca_cnt; // shared clear and read address.

    logic accept;
    logic in_last, pix_last, acq_last, ca_last;

    assign busy = (state == hist_pkg::CLEAR_ALL) || (state == hist_pkg::DRAIN) ||
                  (state == hist_pkg::READOUT);
    assign accept = wr_en && !busy;

    assign in_last  = (in_cnt == IN_MAX);
    assign pix_last = (pix_cnt == PIX_MAX);
    assign acq_last = (acq_cnt == ACQ_MAX);
    assign ca_last  = &ca_cnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= hist_pkg::CLEAR_ALL;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            hist_pkg::CLEAR_ALL: begin
                if (ca_last) next_state = hist_pkg::INPUT_COUNT;
            end
            hist_pkg::INPUT_COUNT, hist_pkg::PIXEL_COUNT, hist_pkg::ACQ_COUNT: begin
                if (accept) begin
                    if (in_last && pix_last && acq_last) next_state = hist_pkg::DRAIN;
                    else if (in_last && pix_last) next_state = hist_pkg::ACQ_COUNT;
                    else if (in_last) next_state = hist_pkg::PIXEL_COUNT;
                    else next_state = hist_pkg::INPUT_COUNT;
                end
            end
            hist_pkg::DRAIN: begin
                if (ram_idle) next_state = hist_pkg::READOUT;
            end
            hist_pkg::READOUT: begin
                if (ca_last) next_state = hist_pkg::CLEAR_ALL;
            end
            default: next_state = hist_pkg::CLEAR_ALL;
        endcase
    end

    // event counters, each wraps and steps the next one.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            in_cnt  <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (accept) begin
            in_cnt <= in_last ? '0 : in_cnt + 1'b1;
            if (in_last) begin
                pix_cnt <= pix_last ? '0 : pix_cnt + 1'b1;
                if (pix_last) acq_cnt <= acq_last ? '0 : acq_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ca_cnt <= '0;
        end else if (clr_en || rd_en) begin
            ca_cnt <= ca_cnt + 1'b1; // wraps to 0 after the top bin.
        end
    end

    assign inc_en   = accept;
    assign inc_ev   = ev;
    assign clr_en   = (state == hist_pkg::CLEAR_ALL);
    assign clr_addr = ca_cnt;
    assign rd_en    = (state == hist_pkg::READOUT);
    assign rd_addr  = ca_cnt;
    assign rd_last  = rd_en && ca_last;

endmodule

/* tb_hist_builder.sv */
`timescale 1ns/1ps
`include "hist_macros.svh"

module tb_hist_builder;

    localparam int EVENTS    = `HIST_DATA_NUM * `HIST_PIXEL_NUM * `HIST_ACQ_NUM;
    localparam int BUSY_WAIT = 64;
    localparam int BIN_WAIT  = 64;
    localparam logic [`HIST_PEAK_MAX-1:0] PEAK_ONE  = `HIST_PEAK_MAX'(1);
    localparam logic [`HIST_PEAK_MAX-1:0] PEAK_FULL = '1;

    logic                clk;
    logic                res;
    logic                wr_en;
    logic [`HIST_NB-1:0] addr;
    logic                busy;
    logic                bin_valid;
    logic                data_finish;
    hist_pkg::hist_bin_t bin_out;

    logic [15:0]               lfsr;
    logic [`HIST_PEAK_MAX-1:0] model [`HIST_BIN_NUM]; // expected count per bin.
    int                        errors;
    int                        checks;
    int                        stream_cycles; // negedges from the last event to the stream end.

    hist_builder i_hist_builder (
        .clk         (clk),
        .res         (res),
        .wr_en       (wr_en),
        .addr        (addr),
        .busy        (busy),
        .bin_valid   (bin_valid),
        .data_finish (data_finish),
        .bin_out     (bin_out)
    );

    always #2 clk = ~clk;

    // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr); // one step per bit.
        end
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("ERROR at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout: %s at %0t ns", what, $time);
        $display("Done: errors found");
        $fatal(1, "simulation stopped after a timeout");
    endtask

    task automatic wait_busy_low(input int limit);
        int n;
        n = 0;
        while (busy && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (busy) timeout_abort("busy stayed high");
    endtask

    task automatic send_event(input logic [`HIST_NB-1:0] a);
        wait_busy_low(BUSY_WAIT);
        wr_en = 1'b1;
        addr  = a;
        if (model[a] != PEAK_FULL) model[a] = model[a] + PEAK_ONE;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic random_histogram();
        logic [7:0] r;
        int k;
        for (k = 0; k < EVENTS; k++) begin
            rand_bits(`HIST_NB, r);
            send_event(r[`HIST_NB-1:0]);
        end
    endtask

    // runs to one bin with idle gaps in which addr keeps moving.
    task automatic burst_histogram();
        logic [7:0]          r;
        logic [`HIST_NB-1:0] bin;
        int run, gap, sent, k;
        sent = 0;
        while (sent < EVENTS) begin
            rand_bits(`HIST_NB, r);
            bin = r[`HIST_NB-1:0];
            rand_bits(3, r);
            run = int'(r[2:0]) + 1;
            for (k = 0; k < run && sent < EVENTS; k++) begin
                send_event(bin);
                sent++;
            end
            rand_bits(1, r);
            if (r[0] && sent < EVENTS) begin
                rand_bits(2, r);
                gap = int'(r[1:0]) + 1;
                for (k = 0; k < gap; k++) begin
                    rand_bits(`HIST_NB, r);
                    addr = r[`HIST_NB-1:0];
                    @(negedge clk);
                end
            end
        end
    endtask

    task automatic collect_bins();
        int n;
        int i;
        n = 0;
        while (!bin_valid && n < BIN_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!bin_valid) timeout_abort("no bin_valid after the last event");
        for (i = 0; i < `HIST_BIN_NUM; i++) begin
            check_value("bin_valid", int'(bin_valid), 1);
            check_value("bin_out.idx", int'(bin_out.idx), i);
            check_value("bin_out.count", int'(bin_out.count), int'(model[i]));
            check_value("data_finish", int'(data_finish), (i == `HIST_BIN_NUM - 1) ? 1 : 0);
            check_value("busy", int'(busy), 1);
            @(negedge clk);
        end
        check_value("bin_valid", int'(bin_valid), 0); // stream is exactly one pass long.
        check_value("data_finish", int'(data_finish), 0);
        stream_cycles = n + `HIST_BIN_NUM;
        for (i = 0; i < `HIST_BIN_NUM; i++) model[i] = '0;
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_start);
        end
    endtask

    initial begin
        int err_start;
        int n;
        logic [7:0] r;
        clk    = 1'b0;
        res    = 1'b0;
        wr_en  = 1'b0;
        addr   = '0;
        lfsr   = 16'd46;
        errors = 0;
        checks = 0;
        stream_cycles = 0;
        for (n = 0; n < `HIST_BIN_NUM; n++) model[n] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        res = 1'b1;

        err_start = errors;
        check_value("busy", int'(busy), 1); // clear phase runs after reset.
        n = 0;
        while (busy && n < BUSY_WAIT) begin
            check_value("bin_valid", int'(bin_valid), 0);
            check_value("data_finish", int'(data_finish), 0);
            @(negedge clk);
            n++;
        end
        if (busy) timeout_abort("busy did not fall after reset");
        repeat (24) begin
            check_value("bin_valid", int'(bin_valid), 0);
            check_value("data_finish", int'(data_finish), 0);
            @(negedge clk);
        end
        report_test(1, "reset", err_start);

        err_start = errors;
        random_histogram();
        collect_bins();
        report_test(2, "random histogram", err_start);

        err_start = errors;
        burst_histogram();
        collect_bins();
        report_test(3, "bursts and gaps", err_start);

        err_start = errors;
        rand_bits(`HIST_NB, r);
        repeat (EVENTS) send_event(r[`HIST_NB-1:0]);
        collect_bins();
        report_test(4, "saturation", err_start);

        err_start = errors;
        check_value("busy", int'(busy), 1); // bin memory is being cleared.
        n = stream_cycles;
        while (busy && n < stream_cycles + BUSY_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) timeout_abort("busy stayed high after the readout");
        checks++;
        // drain, then 16 reads and 16 clears.
        assert (n >= 2 * `HIST_BIN_NUM + 1) else begin
            $display("busy fell after %0d cycles, before readout and clear were done", n);
            errors++;
        end
        random_histogram();
        collect_bins();
        report_test(5, "clear between histograms", err_start);

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
